// ==== logic/buf_pkg.sv ====
`default_nettype none

package buf_pkg;

   // host bus word and stream byte
   localparam int unsigned wb_data_w = 32;
   localparam int unsigned byte_w = 8;

   // one select line per byte lane
   localparam int unsigned wb_sel_w = wb_data_w / byte_w;

   // byte lanes per word, as an address shift
   localparam int unsigned word_lsb_w = $clog2(wb_sel_w);

   // default buffer of 256 bytes
   localparam int unsigned buf_addr_w = 8;
   localparam int unsigned word_addr_w = buf_addr_w - word_lsb_w;

   // wishbone word address bit that picks register space over the data window
   localparam int unsigned reg_sel_bit = word_addr_w;

   // register offsets inside the register space
   localparam int unsigned reg_ctrl_off = 0;

   // control register, start flag and byte count
   localparam int unsigned ctrl_start_bit = 31;
   localparam int unsigned ctrl_len_lsb = 0;

   // status read value
   localparam int unsigned stat_busy_bit = 0;

endpackage

`default_nettype wire

// ==== logic/stream_ctrl_if.sv ====
`default_nettype none

interface stream_ctrl_if #(
   parameter int ADDR_W = 8
);

   // one-cycle request, only issued while the engine is idle
   logic start;

   // bytes to send, one more bit than the byte address
   logic [ADDR_W:0] length;

   // engine state
   logic busy;
   logic done;

   modport ctrl (
      output start,
      output length,
      input  busy,
      input  done
   );

   modport engine (
      input  start,
      input  length,
      output busy,
      output done
   );

endinterface

`default_nettype wire

// ==== logic/t2p_ram.sv ====
`default_nettype none

module t2p_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 6
) (
   input  logic              r_clk,

   // write port
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,

   // read port
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output register holds its value between reads
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

// ==== logic/asym_ram.sv ====
`default_nettype none

module asym_ram #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W = 8,
   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int N = MAX_W / MIN_W,
   localparam int SEL_W = $clog2(N),
   localparam int L_ADDR_W = ADDR_W - SEL_W,
   localparam int W_ADDR_W = (W_DATA_W == MAX_W) ? L_ADDR_W : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W == MAX_W) ? L_ADDR_W : ADDR_W
) (
   input  logic                r_clk,

   // write port
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,

   // read port
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   logic [N-1:0]        en_wr;
   logic [MIN_W-1:0]    data_wr [N];
   logic [L_ADDR_W-1:0] addr_wr;
   logic [L_ADDR_W-1:0] addr_rd;
   logic [MIN_W-1:0]    data_rd [N];

   for (genvar i = 0; i < N; i++) begin : g_blk
      t2p_ram #(
         .DATA_W(MIN_W),
         .ADDR_W(L_ADDR_W)
      ) u_blk (
         .r_clk  (r_clk),
         .w_en   (en_wr[i]),
         .w_addr (addr_wr),
         .w_data (data_wr[i]),
         .r_en   (r_en),
         .r_addr (addr_rd),
         .r_data (data_rd[i])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wr_wide
      logic [SEL_W-1:0] r_sel;

      // every block takes its own slice of the wide word
      for (genvar j = 0; j < N; j++) begin : g_lane
         assign en_wr[j] = w_en;
         assign data_wr[j] = w_data[j*MIN_W +: MIN_W];
      end
      assign addr_wr = w_addr;
      assign addr_rd = r_addr[R_ADDR_W-1:SEL_W];

      // low read address picks the block once its data is out
      always_ff @(posedge r_clk) begin
         if (r_en) begin
            r_sel <= r_addr[SEL_W-1:0];
         end
      end
      assign r_data = data_rd[r_sel];
   end else if (W_DATA_W < R_DATA_W) begin : g_rd_wide
      // low write address steers the enable to one block
      for (genvar j = 0; j < N; j++) begin : g_lane
         assign en_wr[j] = w_en && (w_addr[SEL_W-1:0] == SEL_W'(j));
         assign data_wr[j] = w_data;
         assign r_data[j*MIN_W +: MIN_W] = data_rd[j];
      end
      assign addr_wr = w_addr[W_ADDR_W-1:SEL_W];
      assign addr_rd = r_addr;
   end else begin : g_same
      assign en_wr[0] = w_en;
      assign data_wr[0] = w_data;
      assign addr_wr = w_addr;
      assign addr_rd = r_addr;
      assign r_data = data_rd[0];
   end

   a_ratio_pow2: assert property (@(posedge r_clk)
      (MAX_W % MIN_W == 0) && ((N & (N - 1)) == 0));

   // once the enables settle out of reset they stay known
   a_en_known: assert property (@(posedge r_clk)
      !$isunknown({w_en, r_en}) |=> !$isunknown({w_en, r_en}));

endmodule

`default_nettype wire

// ==== logic/wb_buffer_slave.sv ====
`default_nettype none

module wb_buffer_slave #(
   parameter int ADDR_W = 8,
   localparam int WORD_AW = ADDR_W - buf_pkg::word_lsb_w
) (
   input  logic                          r_clk,
   input  logic                          rst,

   // wishbone classic slave
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [WORD_AW:0]              wb_adr,
   input  logic [buf_pkg::wb_data_w-1:0] wb_dat_w,
   input  logic [buf_pkg::wb_sel_w-1:0]  wb_sel,
   output logic [buf_pkg::wb_data_w-1:0] wb_dat_r,
   output logic                          wb_ack,

   // buffer write port
   output logic                          ram_w_en,
   output logic [WORD_AW-1:0]            ram_w_addr,
   output logic [buf_pkg::wb_data_w-1:0] ram_w_data,

   stream_ctrl_if.ctrl                   ctl
);

   logic                          req;
   logic                          reg_hit;
   logic                          full_sel;
   logic                          ctrl_wr;
   logic [ADDR_W:0]               new_len;
   logic [buf_pkg::wb_data_w-1:0] stat_word;

   // a request is new until it has been acked
   assign req = wb_cyc && wb_stb && !wb_ack;

   assign reg_hit = wb_adr[buf_pkg::reg_sel_bit] &&
                    (wb_adr[WORD_AW-1:0] == WORD_AW'(buf_pkg::reg_ctrl_off));

   // byte enables are all or nothing
   assign full_sel = &wb_sel;

   assign ctrl_wr = req && wb_we && full_sel && reg_hit;
   assign new_len = wb_dat_w[buf_pkg::ctrl_len_lsb +: ADDR_W+1];

   // data window write lands on the ack edge
   assign ram_w_en = req && wb_we && full_sel && !wb_adr[buf_pkg::reg_sel_bit];
   assign ram_w_addr = wb_adr[WORD_AW-1:0];
   assign ram_w_data = wb_dat_w;

   always_comb begin
      stat_word = '0;
      stat_word[buf_pkg::stat_busy_bit] = ctl.busy;
   end

   always_ff @(posedge r_clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
         ctl.start <= 1'b0;
         ctl.length <= '0;
      end else begin
         wb_ack <= req;
         ctl.start <= 1'b0;
         if (ctrl_wr) begin
            ctl.length <= new_len;
            // a start while a run is going is dropped
            if (wb_dat_w[buf_pkg::ctrl_start_bit] && !ctl.busy && (new_len != '0)) begin
               ctl.start <= 1'b1;
            end
         end
      end
   end

   // read data goes out with the ack, data window reads as zero
   always_ff @(posedge r_clk) begin
      if (req && !wb_we) begin
         wb_dat_r <= reg_hit ? stat_word : '0;
      end
   end

   a_ack_follows_req: assert property (@(posedge r_clk) disable iff (rst)
      wb_ack |-> $past(wb_cyc && wb_stb));

   // handshake with the streamer
   a_start_then_busy: assert property (@(posedge r_clk) disable iff (rst)
      ctl.start |=> ctl.busy);

   a_done_then_idle: assert property (@(posedge r_clk) disable iff (rst)
      ctl.done |=> !ctl.busy);

endmodule

`default_nettype wire

// ==== logic/byte_streamer.sv ====
`default_nettype none

module byte_streamer #(
   parameter int ADDR_W = 8
) (
   input  logic                        r_clk,
   input  logic                        rst,

   stream_ctrl_if.engine               ctl,

   // buffer read port
   output logic                        ram_r_en,
   output logic [ADDR_W-1:0]           ram_r_addr,
   input  logic [buf_pkg::byte_w-1:0]  ram_r_data,

   // byte stream out
   output logic [buf_pkg::byte_w-1:0]  out_data,
   output logic                        out_valid,
   input  logic                        out_ready
);

   typedef enum logic [1:0] {
      IDLE,
      FETCH,
      PRESENT
   } state_t;

   state_t          state;
   logic            rd_wait;
   logic [ADDR_W-1:0] addr;
   logic [ADDR_W:0] len_q;
   logic            last;
   logic            accept;

   // first fetch cycle reads, second one captures
   assign ram_r_en = (state == FETCH) && !rd_wait;
   assign ram_r_addr = addr;

   assign out_valid = (state == PRESENT);
   assign accept = out_valid && out_ready;
   assign last = ({1'b0, addr} == (len_q - 1'b1));

   assign ctl.busy = (state != IDLE);
   assign ctl.done = accept && last;

   always_ff @(posedge r_clk) begin
      if (rst) begin
         state <= IDLE;
         rd_wait <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               rd_wait <= 1'b0;
               if (ctl.start) begin
                  state <= FETCH;
               end
            end
            FETCH: begin
               rd_wait <= !rd_wait;
               if (rd_wait) begin
                  state <= PRESENT;
               end
            end
            PRESENT: begin
               if (accept) begin
                  state <= last ? IDLE : FETCH;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // byte pointer and run length, latched at start
   always_ff @(posedge r_clk) begin
      if ((state == IDLE) && ctl.start) begin
         addr <= '0;
         len_q <= ctl.length;
      end else if (accept) begin
         addr <= addr + 1'b1;
      end
   end

   // output byte register
   always_ff @(posedge r_clk) begin
      if ((state == FETCH) && rd_wait) begin
         out_data <= ram_r_data;
      end
   end

   a_hold_stalled: assert property (@(posedge r_clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

// ==== logic/byte_buffer_top.sv ====
`default_nettype none

module byte_buffer_top #(
   parameter int ADDR_W = buf_pkg::buf_addr_w,
   localparam int WORD_AW = ADDR_W - buf_pkg::word_lsb_w
) (
   input  logic                          r_clk,
   input  logic                          rst,

   // wishbone classic
   input  logic                          wb_cyc,
   input  logic                          wb_stb,
   input  logic                          wb_we,
   input  logic [WORD_AW:0]              wb_adr,
   input  logic [buf_pkg::wb_data_w-1:0] wb_dat_w,
   input  logic [buf_pkg::wb_sel_w-1:0]  wb_sel,
   output logic [buf_pkg::wb_data_w-1:0] wb_dat_r,
   output logic                          wb_ack,

   // byte stream
   output logic [buf_pkg::byte_w-1:0]    out_data,
   output logic                          out_valid,
   input  logic                          out_ready
);

   logic                          ram_w_en;
   logic [WORD_AW-1:0]            ram_w_addr;
   logic [buf_pkg::wb_data_w-1:0] ram_w_data;
   logic                          ram_r_en;
   logic [ADDR_W-1:0]             ram_r_addr;
   logic [buf_pkg::byte_w-1:0]    ram_r_data;

   stream_ctrl_if #(.ADDR_W(ADDR_W)) ctl ();

   wb_buffer_slave #(.ADDR_W(ADDR_W)) u_slave (
      .r_clk      (r_clk),
      .rst        (rst),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .ram_w_en   (ram_w_en),
      .ram_w_addr (ram_w_addr),
      .ram_w_data (ram_w_data),
      .ctl        (ctl.ctrl)
   );

   byte_streamer #(.ADDR_W(ADDR_W)) u_streamer (
      .r_clk      (r_clk),
      .rst        (rst),
      .ctl        (ctl.engine),
      .ram_r_en   (ram_r_en),
      .ram_r_addr (ram_r_addr),
      .ram_r_data (ram_r_data),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   // wide word in, single byte out
   asym_ram #(
      .W_DATA_W (buf_pkg::wb_data_w),
      .R_DATA_W (buf_pkg::byte_w),
      .ADDR_W   (ADDR_W)
   ) u_ram (
      .r_clk  (r_clk),
      .w_en   (ram_w_en),
      .w_addr (ram_w_addr),
      .w_data (ram_w_data),
      .r_en   (ram_r_en),
      .r_addr (ram_r_addr),
      .r_data (ram_r_data)
   );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 10,
   parameter int RESET_CYCLES = 3
) (
   output logic r_clk,
   output logic rst
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      r_clk = 1'b0;
      forever #(PERIOD_NS / 2.0) r_clk = ~r_clk;
   end

   // release on a falling edge like every other input
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge r_clk);
      @(negedge r_clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== bench/byte_buffer_tb.sv ====
`default_nettype none

module byte_buffer_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W = buf_pkg::buf_addr_w;
   localparam int WORD_AW = ADDR_W - buf_pkg::word_lsb_w;
   localparam int N_WORDS = 2 ** WORD_AW;
   localparam int N_BYTES = 2 ** ADDR_W;
   localparam int WAIT_LIMIT = 4000;
   localparam logic [WORD_AW:0] CTRL_ADR =
      (WORD_AW+1)'((1 << buf_pkg::reg_sel_bit) + buf_pkg::reg_ctrl_off);
   localparam logic [31:0] START_FLAG = 32'(1) << buf_pkg::ctrl_start_bit;
   localparam logic [31:0] BUSY_FLAG = 32'(1) << buf_pkg::stat_busy_bit;

   logic                          r_clk;
   logic                          rst;
   logic                          wb_cyc;
   logic                          wb_stb;
   logic                          wb_we;
   logic [WORD_AW:0]              wb_adr;
   logic [buf_pkg::wb_data_w-1:0] wb_dat_w;
   logic [buf_pkg::wb_sel_w-1:0]  wb_sel;
   logic [buf_pkg::wb_data_w-1:0] wb_dat_r;
   logic                          wb_ack;
   logic [buf_pkg::byte_w-1:0]    out_data;
   logic                          out_valid;
   logic                          out_ready;

   // host view of the buffer, one entry per word
   logic [31:0] shadow [N_WORDS];
   logic [31:0] data_rng;
   logic [31:0] ready_rng;
   logic [31:0] stat;
   logic [31:0] rd_word;
   logic        stall_en;
   logic        prev_stall;
   logic [7:0]  prev_data;
   int          rx_count;

   tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) clk_gen_i (
      .r_clk (r_clk),
      .rst   (rst)
   );

   byte_buffer_top #(.ADDR_W(ADDR_W)) dut_i (
      .r_clk     (r_clk),
      .rst       (rst),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_sel    (wb_sel),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // byte k of word w sits at byte address 4w+k
   function automatic logic [7:0] expected_byte(input int addr);
      logic [31:0] word;
      word = shadow[addr / buf_pkg::wb_sel_w];
      return word[8 * (addr % buf_pkg::wb_sel_w) +: 8];
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else abort_run($sformatf("** Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
   endtask

   task automatic wb_write(input logic [WORD_AW:0] adr, input logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge r_clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b1;
      wb_adr = adr;
      wb_dat_w = data;
      wb_sel = '1;
      do begin
         @(negedge r_clk);
         waited++;
      end while (!wb_ack && waited < WAIT_LIMIT);
      if (!wb_ack) begin
         abort_run("wb_ack never came back for a write");
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      if (!adr[buf_pkg::reg_sel_bit]) begin
         shadow[adr[WORD_AW-1:0]] = data;
      end
   endtask

   task automatic wb_read(input logic [WORD_AW:0] adr, output logic [31:0] data);
      int waited;
      waited = 0;
      @(negedge r_clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b0;
      wb_adr = adr;
      do begin
         @(negedge r_clk);
         waited++;
      end while (!wb_ack && waited < WAIT_LIMIT);
      if (!wb_ack) begin
         abort_run("wb_ack never came back for a read");
      end
      data = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic start_run(input int len);
      rx_count = 0;
      wb_write(CTRL_ADR, START_FLAG | 32'(len));
   endtask

   task automatic wait_idle();
      int tries;
      tries = 0;
      wb_read(CTRL_ADR, stat);
      while (stat[buf_pkg::stat_busy_bit] && tries < 100) begin
         wb_read(CTRL_ADR, stat);
         tries++;
      end
      if (stat[buf_pkg::stat_busy_bit]) begin
         abort_run("status kept reading busy after the run ended");
      end
   endtask

   // waits for the byte count and the end of the run, then makes sure nothing more came
   task automatic wait_bytes(input int len);
      int waited;
      waited = 0;
      while (rx_count < len && waited < WAIT_LIMIT) begin
         @(negedge r_clk);
         waited++;
      end
      if (rx_count < len) begin
         abort_run($sformatf("stream stopped after %0d of %0d bytes", rx_count, len));
      end
      wait_idle();
      check_value("byte count", rx_count, len);
   endtask

   // random back-pressure, about one stall in four
   always @(negedge r_clk) begin
      if (stall_en) begin
         ready_rng = xorshift32(ready_rng);
         out_ready = (ready_rng[1:0] != 2'b00);
      end else begin
         out_ready = 1'b1;
      end
   end

   // stream checker
   always @(posedge r_clk) begin
      if (rst) begin
         prev_stall = 1'b0;
      end else begin
         if (prev_stall) begin
            assert (out_valid)
            else abort_run("out_valid dropped before the stalled byte was taken");
            check_value("stalled out_data", out_data, prev_data);
         end
         if (out_valid && out_ready) begin
            check_value($sformatf("stream byte %0d", rx_count), out_data,
                        expected_byte(rx_count));
            rx_count++;
         end
         prev_stall = out_valid && !out_ready;
         prev_data = out_data;
      end
   end

   initial begin
      int waited;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      wb_sel = '0;
      out_ready = 1'b1;
      stall_en = 1'b0;
      rx_count = 0;
      data_rng = 32'hbcc9_112e;
      ready_rng = xorshift32(32'hbcc9_112e ^ 32'h5555_aaaa);
      for (int i = 0; i < N_WORDS; i++) begin
         shadow[i] = '0;
      end

      waited = 0;
      while (rst !== 1'b0 && waited < 20) begin
         @(negedge r_clk);
         waited++;
      end
      if (rst !== 1'b0) begin
         abort_run("reset was never released");
      end

      // quiet after reset
      check_value("wb_ack after reset", wb_ack, 0);
      check_value("out_valid after reset", out_valid, 0);
      wb_read(CTRL_ADR, stat);
      check_value("status after reset", stat, 32'h0);

      // full buffer, no back-pressure
      for (int w = 0; w < N_WORDS; w++) begin
         data_rng = xorshift32(data_rng);
         wb_write(WORD_AW'(w), data_rng);
      end

      // host side cannot read the buffer back
      wb_read(WORD_AW'(1), rd_word);
      check_value("data window read", rd_word, 32'h0);

      start_run(N_BYTES);
      wait_bytes(N_BYTES);

      // partial run with stalls, status and a second start while busy
      stall_en = 1'b1;
      start_run(37);
      wb_read(CTRL_ADR, stat);
      check_value("status while streaming", stat, BUSY_FLAG);
      wb_write(CTRL_ADR, START_FLAG | 32'd10);
      wait_bytes(37);
      stall_en = 1'b0;

      // zero length must not start anything
      rx_count = 0;
      wb_write(CTRL_ADR, START_FLAG);
      for (int c = 0; c < 50; c++) begin
         @(negedge r_clk);
         check_value("out_valid after zero-length start", out_valid, 0);
      end
      check_value("bytes after zero-length start", rx_count, 0);
      wb_read(CTRL_ADR, stat);
      check_value("status after zero-length start", stat, 32'h0);

      // overwrite a few words and stream again
      for (int k = 0; k < 8; k++) begin
         data_rng = xorshift32(data_rng);
         wb_write(WORD_AW'(data_rng[13:8]), xorshift32(data_rng));
      end
      start_run(N_BYTES);
      wait_bytes(N_BYTES);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/buf_pkg.sv
logic/stream_ctrl_if.sv
logic/t2p_ram.sv
logic/asym_ram.sv
logic/wb_buffer_slave.sv
logic/byte_streamer.sv
logic/byte_buffer_top.sv
bench/tb_clock_gen.sv
bench/byte_buffer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = byte_buffer_tb
RTL_TOP   = byte_buffer_top
FILELIST  = sources.f
BUILD_DIR = obj_dir
SIM_BIN   = sim_$(TOP)
PASS_MSG  = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
